/* filelist.f */
+incdir+tb
logic/power_pkg.sv
logic/power_regs.sv
logic/camera_power_seq.sv
logic/power_ctrl_top.sv
tb/tb_power_ctrl.sv

/* logic/camera_power_seq.sv */
`timescale 1ns/1ps

module camera_power_seq
	import power_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               cmd_valid,
	input  logic               cam_on,     // this camera's command bit
	input  logic [pulse_w-1:0] pulse_len,
	output logic               camera_pwr_en,
	output logic               camera_rst,
	output logic               cam_busy
);

	cam_state_t          state;
	logic [pulse_w-1:0]  pulse_cnt;   // cycles within one pulse period
	logic [settle_w-1:0] period_cnt;  // pulse periods spent settling
	logic                pulse_done;

	// last cycle of the current period; a zero length acts as one cycle
	assign pulse_done = (pulse_cnt + pulse_w'(1)) >= pulse_len;

	assign cam_busy = (state != cam_idle);

	// ----------------------------------------------------------------------
	// sequencer
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state         <= cam_rst_pulse;  // powered and reset after rst_n
			pulse_cnt     <= '0;
			period_cnt    <= '0;
			camera_pwr_en <= 1'b1;
			camera_rst    <= 1'b0;
		end else begin
			case (state)
				cam_idle: begin
					camera_rst <= 1'b0;
					pulse_cnt  <= '0;
					period_cnt <= '0;
					if (cmd_valid) begin
						if (camera_pwr_en && !cam_on) begin
							camera_pwr_en <= 1'b0;  // close at once
						end else if (!camera_pwr_en && cam_on) begin
							state <= cam_pwr_wait;
						end
					end
				end

				cam_pwr_wait: begin
					camera_pwr_en <= 1'b1;
					if (pulse_done) begin
						pulse_cnt <= '0;
						if (period_cnt == settle_last) begin
							period_cnt <= '0;
							state      <= cam_rst_pulse;
						end else begin
							period_cnt <= period_cnt + settle_w'(1);
						end
					end else begin
						pulse_cnt <= pulse_cnt + pulse_w'(1);
					end
				end

				cam_rst_pulse: begin
					camera_rst <= 1'b1;  // held for one pulse period
					if (pulse_done) begin
						pulse_cnt <= '0;
						state     <= cam_idle;
					end else begin
						pulse_cnt <= pulse_cnt + pulse_w'(1);
					end
				end

				default: begin
					state <= cam_idle;
				end
			endcase
		end
	end

endmodule

/* logic/power_ctrl_top.sv */
`timescale 1ns/1ps

module power_ctrl_top
	import power_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,

	// apb slave
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [apb_addr_w-1:0]  paddr,
	input  logic [apb_data_w-1:0]  pwdata,
	output logic [apb_data_w-1:0]  prdata,
	output logic                   pready,
	output logic                   pslverr,

	// power outputs
	output logic                   sensor_pwr_en,
	output logic                   motor_pwr_en,
	output logic [num_cameras-1:0] camera_pwr_en,
	output logic [num_cameras-1:0] camera_rst
);

	logic                  cmd_valid;
	logic [apb_data_w-1:0] cmd_word;
	logic [pulse_w-1:0]    pulse_len;
	logic [num_cameras-1:0] cam_busy;

	// ----------------------------------------------------------------------
	// register block
	// ----------------------------------------------------------------------
	power_regs u_regs (
		.clk           (clk),
		.rst_n         (rst_n),
		.psel          (psel),
		.penable       (penable),
		.pwrite        (pwrite),
		.paddr         (paddr),
		.pwdata        (pwdata),
		.prdata        (prdata),
		.pready        (pready),
		.pslverr       (pslverr),
		.cam_busy      (cam_busy),
		.camera_pwr_en (camera_pwr_en),
		.camera_rst    (camera_rst),
		.cmd_valid     (cmd_valid),
		.cmd_word      (cmd_word),
		.pulse_len     (pulse_len),
		.sensor_pwr_en (sensor_pwr_en),
		.motor_pwr_en  (motor_pwr_en)
	);

	// ----------------------------------------------------------------------
	// one sequencer per camera
	// ----------------------------------------------------------------------
	for (genvar i = 0; i < num_cameras; i++) begin : g_cam
		camera_power_seq u_seq (
			.clk           (clk),
			.rst_n         (rst_n),
			.cmd_valid     (cmd_valid),
			.cam_on        (cmd_word[camera_bit_lo + i]),  // camera i request bit
			.pulse_len     (pulse_len),
			.camera_pwr_en (camera_pwr_en[i]),
			.camera_rst    (camera_rst[i]),
			.cam_busy      (cam_busy[i])
		);
	end

endmodule

/* logic/power_pkg.sv */
package power_pkg;

	// ----------------------------------------------------------------------
	// channel count and bus widths
	// ----------------------------------------------------------------------
	localparam int num_cameras = 5;
	localparam int apb_addr_w  = 4;
	localparam int apb_data_w  = 32;

	// command word bit positions
	localparam int sensor_pwr_bit = 21;
	localparam int motor_pwr_bit  = 22;
	localparam int camera_bit_lo  = 24;  // cameras 0..4 on bits 24..28

	// status word field positions, sensor and motor share the command bits
	localparam int stat_pwr_lo  = 0;
	localparam int stat_rst_lo  = 8;
	localparam int stat_busy_lo = 16;

	// ----------------------------------------------------------------------
	// sequencer timing
	// ----------------------------------------------------------------------
	localparam int pulse_w     = 16;
	localparam int settle_mult = 4;      // pulse periods spent on power settle
	localparam int settle_w    = $clog2(settle_mult);

	localparam logic [settle_w-1:0] settle_last   = settle_w'(settle_mult - 1);
	localparam logic [pulse_w-1:0]  pulse_default = 16'd8;  // short default period

	// register map
	localparam logic [apb_addr_w-1:0] addr_cmd    = 4'h0;
	localparam logic [apb_addr_w-1:0] addr_pulse  = 4'h4;
	localparam logic [apb_addr_w-1:0] addr_status = 4'h8;

	typedef enum logic [1:0] {
		cam_idle,
		cam_pwr_wait,
		cam_rst_pulse
	} cam_state_t;

endpackage

/* logic/power_regs.sv */
`timescale 1ns/1ps

module power_regs
	import power_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,

	// apb slave
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [apb_addr_w-1:0]  paddr,
	input  logic [apb_data_w-1:0]  pwdata,
	output logic [apb_data_w-1:0]  prdata,
	output logic                   pready,
	output logic                   pslverr,

	// feedback from the sequencers
	input  logic [num_cameras-1:0] cam_busy,
	input  logic [num_cameras-1:0] camera_pwr_en,
	input  logic [num_cameras-1:0] camera_rst,

	// command side
	output logic                   cmd_valid,
	output logic [apb_data_w-1:0]  cmd_word,
	output logic [pulse_w-1:0]     pulse_len,
	output logic                   sensor_pwr_en,
	output logic                   motor_pwr_en
);

	logic                  access;
	logic                  addr_ok;
	logic                  wr_cmd;
	logic                  wr_pulse;
	logic [apb_data_w-1:0] status_word;

	// ----------------------------------------------------------------------
	// transfer decode
	// ----------------------------------------------------------------------
	assign access = psel & penable;  // access phase of a transfer
	assign pready = 1'b1;            // no wait states

	always_comb begin
		case (paddr)
			addr_cmd:    addr_ok = 1'b1;
			addr_pulse:  addr_ok = 1'b1;
			addr_status: addr_ok = ~pwrite;  // read only
			default:     addr_ok = 1'b0;
		endcase
	end

	assign pslverr  = access & ~addr_ok;
	assign wr_cmd   = access & pwrite & (paddr == addr_cmd);
	assign wr_pulse = access & pwrite & (paddr == addr_pulse);

	// ----------------------------------------------------------------------
	// command register and power enables
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cmd_word      <= '0;
			cmd_valid     <= 1'b0;
			sensor_pwr_en <= 1'b0;
			motor_pwr_en  <= 1'b0;
		end else begin
			cmd_valid <= wr_cmd;  // one cycle strobe to the sequencers
			if (wr_cmd) begin
				cmd_word      <= pwdata;
				sensor_pwr_en <= pwdata[sensor_pwr_bit];
				motor_pwr_en  <= pwdata[motor_pwr_bit];
			end
		end
	end

	// pulse period, low bits only
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pulse_len <= pulse_default;
		end else if (wr_pulse) begin
			pulse_len <= pwdata[pulse_w-1:0];
		end
	end

	// ----------------------------------------------------------------------
	// status and read mux
	// ----------------------------------------------------------------------
	always_comb begin
		status_word = '0;
		status_word[stat_pwr_lo  +: num_cameras] = camera_pwr_en;
		status_word[stat_rst_lo  +: num_cameras] = camera_rst;
		status_word[stat_busy_lo +: num_cameras] = cam_busy;
		status_word[sensor_pwr_bit] = sensor_pwr_en;
		status_word[motor_pwr_bit]  = motor_pwr_en;
	end

	// data is valid in the access cycle
	always_comb begin
		case (paddr)
			addr_cmd:    prdata = cmd_word;
			addr_pulse:  prdata = {{(apb_data_w - pulse_w){1'b0}}, pulse_len};
			addr_status: prdata = status_word;
			default:     prdata = '0;
		endcase
	end

endmodule

/* run.sh */
#!/bin/sh
# build and run the power controller testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f filelist.f \
	--top-module tb_power_ctrl \
	-o tb_power_ctrl
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_power_ctrl)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the verdict line from the testbench decides the result
if printf '%s\n' "$out" | grep -qx "test passed"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1

/* tb/tb_apb_tasks.svh */
`ifndef tb_apb_tasks_svh
`define tb_apb_tasks_svh

// ----------------------------------------------------------------------
// checks and random values
// ----------------------------------------------------------------------
task automatic check_cond(input logic cond, input string msg);
	assert (cond) else begin
		$display("ERROR %0t: %s", $time, msg);
		errors++;
	end
endtask

// galois form, right shift, maximal length 32-bit polynomial
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'hB4BCD35C) : (s >> 1);
endfunction

function automatic logic [31:0] take_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int k = 0; k < n; k++) begin
		lfsr_state = lfsr_next(lfsr_state);  // one step per bit
		v = {v[30:0], lfsr_state[0]};
	end
	return v;
endfunction

// ----------------------------------------------------------------------
// apb transfers, called on a falling edge and return on one
// ----------------------------------------------------------------------
task automatic apb_write(input logic [apb_addr_w-1:0] addr,
		input logic [apb_data_w-1:0] data, input logic exp_err);
	psel    = 1'b1;  // setup cycle
	penable = 1'b0;
	pwrite  = 1'b1;
	paddr   = addr;
	pwdata  = data;
	@(negedge clk);
	penable = 1'b1;  // access cycle
	#(clk_period / 4);
	check_cond(pslverr == exp_err, $sformatf("write to 0x%0h gave pslverr %0b, expected %0b",
		addr, pslverr, exp_err));
	@(negedge clk);
	psel    = 1'b0;
	penable = 1'b0;
endtask

task automatic apb_read(input logic [apb_addr_w-1:0] addr,
		output logic [apb_data_w-1:0] data, input logic exp_err);
	psel    = 1'b1;
	penable = 1'b0;
	pwrite  = 1'b0;
	paddr   = addr;
	pwdata  = '0;
	@(negedge clk);
	penable = 1'b1;
	#(clk_period / 4);
	data = prdata;  // valid in the access cycle
	check_cond(pslverr == exp_err, $sformatf("read of 0x%0h gave pslverr %0b, expected %0b",
		addr, pslverr, exp_err));
	@(negedge clk);
	psel    = 1'b0;
	penable = 1'b0;
endtask

`endif

/* tb/tb_power_ctrl.sv */
`timescale 1ns/1ps

module tb_power_ctrl
	import power_pkg::*;
();

	localparam int clk_period     = 8;
	localparam int timeout_cycles = 6 * (6 * 8 + 40);  // six tests at pulse length 8

	logic                   clk;
	logic                   rst_n;
	logic                   psel;
	logic                   penable;
	logic                   pwrite;
	logic [apb_addr_w-1:0]  paddr;
	logic [apb_data_w-1:0]  pwdata;
	logic [apb_data_w-1:0]  prdata;
	logic                   pready;
	logic                   pslverr;
	logic                   sensor_pwr_en;
	logic                   motor_pwr_en;
	logic [num_cameras-1:0] camera_pwr_en;
	logic [num_cameras-1:0] camera_rst;

	int          cycle;
	int          errors;       // sequence checks
	int          mon_errors;   // timing windows
	int          sva_errors;
	int          n_pass;
	int          n_fail;
	int          test_num;
	int          errors_at_start;
	int          exp_pulse;    // pulse length the monitor expects
	logic [31:0] lfsr_state;

	logic [num_cameras-1:0] prev_pwr;
	logic [num_cameras-1:0] prev_rst;
	logic [num_cameras-1:0] armed = '0;  // power rose and settle not yet timed
	int                     pwr_rise [num_cameras];
	int                     rst_rise [num_cameras];
	int                     rst_count [num_cameras];
	int                     base_count [num_cameras];

	`include "tb_apb_tasks.svh"

	power_ctrl_top dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.psel          (psel),
		.penable       (penable),
		.pwrite        (pwrite),
		.paddr         (paddr),
		.pwdata        (pwdata),
		.prdata        (prdata),
		.pready        (pready),
		.pslverr       (pslverr),
		.sensor_pwr_en (sensor_pwr_en),
		.motor_pwr_en  (motor_pwr_en),
		.camera_pwr_en (camera_pwr_en),
		.camera_rst    (camera_rst)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= timeout_cycles) begin
			$display("timeout: run did not finish within %0d cycles", timeout_cycles);
			$display("test failed");
			$finish;
		end
	end

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------
	function automatic int total_errors();
		return errors + mon_errors + sva_errors;
	endfunction

	function automatic logic [apb_data_w-1:0] make_cmd(input logic [num_cameras-1:0] cams,
			input logic sensor, input logic motor);
		logic [apb_data_w-1:0] w;
		w = '0;
		w[camera_bit_lo +: num_cameras] = cams;
		w[sensor_pwr_bit] = sensor;
		w[motor_pwr_bit]  = motor;
		return w;
	endfunction

	task automatic check_window(input int cam, input string what, input int got, input int lo);
		assert (got >= lo && got <= lo + 3) else begin
			$display("ERROR %0t: camera %0d %s took %0d cycles, expected %0d to %0d",
				$time, cam, what, got, lo, lo + 3);
			mon_errors++;
		end
	endtask

	task automatic snap_counts();
		for (int i = 0; i < num_cameras; i++) begin
			base_count[i] = rst_count[i];
		end
	endtask

	// until every camera in mask has finished one more reset pulse
	task automatic wait_sequences(input logic [num_cameras-1:0] mask);
		logic waiting;
		waiting = 1'b1;
		while (waiting) begin
			@(posedge clk);  // counts settle on the falling edge
			waiting = 1'b0;
			for (int i = 0; i < num_cameras; i++) begin
				if (mask[i] && rst_count[i] == base_count[i]) waiting = 1'b1;
			end
		end
		@(negedge clk);
	endtask

	task automatic finish_test(input string name);
		if (total_errors() == errors_at_start) begin
			n_pass++;
			$display("[%0d] %s: ok", test_num, name);
		end else begin
			n_fail++;
			$display("[%0d] %s: FAIL, %0d errors", test_num, name,
				total_errors() - errors_at_start);
		end
		test_num++;
		errors_at_start = total_errors();
	endtask

	// ----------------------------------------------------------------------
	// sequence timing monitor sampled on the falling edge
	// ----------------------------------------------------------------------
	always @(negedge clk) begin
		for (int i = 0; i < num_cameras; i++) begin
			if (rst_n && camera_pwr_en[i] && !prev_pwr[i]) begin
				pwr_rise[i] = cycle;
				armed[i] = 1'b1;
			end
			if (rst_n && camera_rst[i] && !prev_rst[i]) begin
				rst_rise[i] = cycle;
				if (armed[i]) begin
					check_window(i, "power settle", cycle - pwr_rise[i], settle_mult * exp_pulse);
				end
				armed[i] = 1'b0;
			end
			if (rst_n && !camera_rst[i] && prev_rst[i]) begin
				check_window(i, "reset pulse", cycle - rst_rise[i], exp_pulse);
				rst_count[i] = rst_count[i] + 1;
			end
			prev_pwr[i] = camera_pwr_en[i];
			prev_rst[i] = camera_rst[i];
		end
	end

	no_wait_states: assert property (@(posedge clk) disable iff (!rst_n) pready)
		else begin
			$display("ERROR %0t: pready low", $time);
			sva_errors++;
		end

	// reset only ever pulses on a powered camera
	rst_needs_power: assert property (@(posedge clk) disable iff (!rst_n)
		(camera_rst & ~camera_pwr_en) == '0)
		else begin
			$display("ERROR %0t: camera reset high without power, rst %b", $time, camera_rst);
			sva_errors++;
		end

	// ----------------------------------------------------------------------
	// tests
	// ----------------------------------------------------------------------
	initial begin
		logic [num_cameras-1:0] mask;
		logic [31:0]            r;
		logic [apb_data_w-1:0]  rd;
		logic [apb_data_w-1:0]  exp_cmd;
		logic [apb_data_w-1:0]  exp_status;
		int                     cam;
		int                     other;
		rst_n      = 1'b0;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		lfsr_state = 32'd78388;
		exp_pulse  = 8;
		test_num   = 1;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;

		@(negedge clk);
		check_cond(camera_pwr_en == '1, "cameras not all powered after reset");
		check_cond(!sensor_pwr_en && !motor_pwr_en, "sensor or motor enabled after reset");
		wait_sequences('1);
		repeat (3) @(negedge clk);
		check_cond(camera_rst == '0, $sformatf("camera reset %b after reset pulse", camera_rst));
		apb_read(addr_pulse, rd, 1'b0);
		check_cond(rd == 32'd8, $sformatf("pulse period read 0x%0h, expected 0x8", rd));
		finish_test("reset state");

		apb_write(addr_cmd, '0, 1'b0);
		repeat (2) @(negedge clk);
		check_cond(camera_pwr_en == '0, $sformatf("power %b after close", camera_pwr_en));
		r    = take_bits(num_cameras);
		mask = r[num_cameras-1:0];
		if (mask == '0) mask[0] = 1'b1;  // open at least one camera
		snap_counts();
		apb_write(addr_cmd, make_cmd(mask, 1'b0, 1'b0), 1'b0);
		wait_sequences(mask);
		check_cond(camera_pwr_en == mask,
			$sformatf("power %b after open, expected %b", camera_pwr_en, mask));
		finish_test("close then open");

		for (int k = 0; k < 3; k++) begin
			r = take_bits(2);
			apb_write(addr_cmd, make_cmd(mask, r[0], r[1]), 1'b0);
			check_cond(sensor_pwr_en == r[0] && motor_pwr_en == r[1],
				$sformatf("sensor %b motor %b, expected %b %b",
				sensor_pwr_en, motor_pwr_en, r[0], r[1]));
			apb_read(addr_status, rd, 1'b0);
			check_cond(rd[sensor_pwr_bit] == r[0] && rd[motor_pwr_bit] == r[1],
				$sformatf("status 0x%0h disagrees with sensor %b motor %b", rd, r[0], r[1]));
			check_cond(rd[num_cameras-1:0] == mask, $sformatf("status power field in 0x%0h", rd));
		end
		finish_test("sensor and motor");

		apb_write(addr_pulse, 32'd3, 1'b0);
		exp_pulse = 3;
		apb_read(addr_pulse, rd, 1'b0);
		check_cond(rd == 32'd3, $sformatf("pulse period read 0x%0h, expected 0x3", rd));
		apb_write(addr_cmd, '0, 1'b0);
		repeat (2) @(negedge clk);
		r    = take_bits(3);
		cam  = int'(r[2:0]) % num_cameras;
		mask = '0;
		mask[cam] = 1'b1;
		snap_counts();
		apb_write(addr_cmd, make_cmd(mask, 1'b0, 1'b0), 1'b0);
		wait_sequences(mask);
		check_cond(camera_pwr_en == mask, $sformatf("power %b, expected %b", camera_pwr_en, mask));
		finish_test("pulse reprogramming");

		other = (cam + 1) % num_cameras;
		mask  = '0;
		mask[other] = 1'b1;
		snap_counts();
		apb_write(addr_cmd, make_cmd(mask, 1'b0, 1'b0), 1'b0);
		apb_read(addr_status, rd, 1'b0);
		check_cond(rd[stat_busy_lo + other] == 1'b1, $sformatf("camera %0d not busy", other));
		apb_write(addr_cmd, '0, 1'b0);  // lands in the settle wait
		wait_sequences(mask);
		check_cond(camera_pwr_en == mask, $sformatf("power %b, expected %b", camera_pwr_en, mask));
		apb_read(addr_status, rd, 1'b0);
		check_cond(rd[stat_busy_lo +: num_cameras] == '0, $sformatf("busy left in 0x%0h", rd));
		finish_test("busy ignore");

		exp_cmd    = make_cmd('0, 1'b0, 1'b0);  // last command written
		exp_status = '0;
		exp_status[num_cameras-1:0] = mask;     // only the busy test camera powered
		r = take_bits(32);
		apb_write(4'hc, r, 1'b1);
		apb_read(4'hc, rd, 1'b1);
		apb_write(addr_status, r, 1'b1);
		repeat (2) @(negedge clk);
		apb_read(addr_cmd, rd, 1'b0);
		check_cond(rd == exp_cmd, $sformatf("command 0x%0h, expected 0x%0h", rd, exp_cmd));
		apb_read(addr_pulse, rd, 1'b0);
		check_cond(rd == 32'd3, $sformatf("pulse period 0x%0h changed from 0x3", rd));
		apb_read(addr_status, rd, 1'b0);
		check_cond(rd == exp_status,
			$sformatf("status 0x%0h, expected 0x%0h", rd, exp_status));
		finish_test("apb errors");

		$display("tests: %0d pass, %0d fail, %0d check errors", n_pass, n_fail, total_errors());
		if (n_fail == 0 && total_errors() == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule
